//--- common/core_defines.svh
// Width and count macros for the execute pipeline, included by the ISA package and the RTL
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Width of a data word and of an instruction word
`define DATA_W 32

// Register address width
`define REG_AW 5

// Number of architectural registers, register zero included
`define REG_N 32

`endif

//--- common/isaPkg.sv
// Instruction formats and encodings, imported by the decode stage to split instruction words
`default_nettype none
`include "core_defines.svh"

package isaPkg;

  // Register-register format
  typedef struct packed {
    logic [5:0]         opcode;
    logic [`REG_AW-1:0] rs;
    logic [`REG_AW-1:0] rt;
    logic [`REG_AW-1:0] rd;
    logic [4:0]         shamt;
    logic [5:0]         funct;
  } rTypeFmt;

  // Register-immediate format, rt is the destination here
  typedef struct packed {
    logic [5:0]         opcode;
    logic [`REG_AW-1:0] rs;
    logic [`REG_AW-1:0] rt;
    logic [15:0]        imm;
  } iTypeFmt;

  // One instruction word read through either format
  typedef union packed {
    rTypeFmt rType;
    iTypeFmt iType;
  } instrWord;

  // Major opcodes
  localparam logic [5:0] opSpecial = 6'h00;
  localparam logic [5:0] opAddi    = 6'h08;
  localparam logic [5:0] opSlti    = 6'h0a;
  localparam logic [5:0] opAndi    = 6'h0c;
  localparam logic [5:0] opOri     = 6'h0d;
  localparam logic [5:0] opLui     = 6'h0f;

  // Function codes under the SPECIAL opcode
  localparam logic [5:0] fnSll = 6'h00;
  localparam logic [5:0] fnSrl = 6'h02;
  localparam logic [5:0] fnAdd = 6'h20;
  localparam logic [5:0] fnSub = 6'h22;
  localparam logic [5:0] fnAnd = 6'h24;
  localparam logic [5:0] fnOr  = 6'h25;
  localparam logic [5:0] fnXor = 6'h26;
  localparam logic [5:0] fnSlt = 6'h2a;
  localparam logic [5:0] fnTeq = 6'h34;
  localparam logic [5:0] fnTne = 6'h36;

endpackage

`default_nettype wire

//--- common/pipePkg.sv
// Pipeline control types shared by decode, the ID/EX register and execute
`default_nettype none

package pipePkg;

  // ALU operation chosen by decode and carried down to execute
  typedef enum logic [3:0] {
    aluAdd = 4'd0,
    aluSub = 4'd1,
    aluAnd = 4'd2,
    aluOr  = 4'd3,
    aluXor = 4'd4,
    aluSlt = 4'd5,
    aluSll = 4'd6,
    aluSrl = 4'd7,
    aluLui = 4'd8
  } aluOp;

  // Condition under which a trap instruction fires
  typedef enum logic {
    trapEq = 1'b0,
    trapNe = 1'b1
  } trapCond;

endpackage

`default_nettype wire

//--- decode/regFile.sv
// Register file of the decode stage with two asynchronous read ports and one write port
`default_nettype none
`include "core_defines.svh"

module regFile (
  input  logic               CLK,
  input  logic               rstN,
  input  logic [`REG_AW-1:0] raddr1,
  input  logic [`REG_AW-1:0] raddr2,
  output logic [`DATA_W-1:0] rdata1,
  output logic [`DATA_W-1:0] rdata2,
  input  logic               we,
  input  logic [`REG_AW-1:0] waddr,
  input  logic [`DATA_W-1:0] wdata
);

  logic [`DATA_W-1:0] regs [`REG_N];

  // Register zero is hardwired, a write to it is dropped
  always_ff @(posedge CLK or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < `REG_N; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  // A write in flight is bypassed so decode sees the new value this cycle
  function automatic logic [`DATA_W-1:0] readPort(input logic [`REG_AW-1:0] addr);
    if (addr == '0) return '0;
    if (we && waddr == addr) return wdata;
    return regs[addr];
  endfunction

  always_comb rdata1 = readPort(raddr1);
  always_comb rdata2 = readPort(raddr2);

endmodule

`default_nettype wire

//--- decode/decodeStage.sv
// Decode stage, takes words over four-phase req/ack, decodes them and issues into ID/EX
`default_nettype none
`include "core_defines.svh"

module decodeStage (
  input  logic               CLK,
  input  logic               rstN,
  input  logic               instrReq,
  output logic               instrAck,
  input  logic [`DATA_W-1:0] instr,
  input  logic               rfWe,
  input  logic [`REG_AW-1:0] rfWaddr,
  input  logic [`DATA_W-1:0] rfWdata,
  input  logic               trapTaken,
  input  logic               exStall,
  output pipePkg::aluOp      aluOp,
  output logic               aluSrcImm,
  output logic               regWrite,
  output logic               trap,
  output pipePkg::trapCond   trapCond,
  output logic               idValid,
  output logic [`DATA_W-1:0] readData1,
  output logic [`DATA_W-1:0] readData2,
  output logic [`DATA_W-1:0] extImm,
  output logic [`REG_AW-1:0] dstReg,
  output logic               idStall
);

  import isaPkg::*;
  import pipePkg::*;

  // The single instruction slot
  logic     slotValid;
  instrWord slotWord;

  // Set while an issued trap is unresolved, then the pending cancel of the next word
  logic shadow;
  logic cancelNext;

  // One bit per register with a write still in flight
  logic [`REG_N-1:0] pending;

  logic [`REG_AW-1:0] rs;
  logic [`REG_AW-1:0] rt;
  logic               signExt;
  logic               hazard;
  logic               issue;
  logic               discard;
  logic               capture;
  logic               resolve;

  // Source fields sit at the same bits in both formats
  assign rs = slotWord.rType.rs;
  assign rt = slotWord.rType.rt;

  always_comb begin
    aluOp     = aluAdd;
    aluSrcImm = 1'b1;
    regWrite  = 1'b1;
    trap      = 1'b0;
    trapCond  = trapEq;
    signExt   = 1'b0;
    dstReg    = slotWord.iType.rt;
    if (slotWord.rType.opcode == opSpecial) begin
      aluSrcImm = 1'b0;
      dstReg    = slotWord.rType.rd;
      case (slotWord.rType.funct)
        fnAdd: aluOp = aluAdd;
        fnSub: aluOp = aluSub;
        fnAnd: aluOp = aluAnd;
        fnOr:  aluOp = aluOr;
        fnXor: aluOp = aluXor;
        fnSlt: aluOp = aluSlt;
        fnSll: aluOp = aluSll;
        fnSrl: aluOp = aluSrl;
        fnTeq: begin
          trap     = 1'b1;
          regWrite = 1'b0;
        end
        fnTne: begin
          trap     = 1'b1;
          regWrite = 1'b0;
          trapCond = trapNe;
        end
        default: regWrite = 1'b0;
      endcase
    end else begin
      case (slotWord.iType.opcode)
        opAddi: signExt = 1'b1;
        opSlti: begin
          aluOp   = aluSlt;
          signExt = 1'b1;
        end
        opAndi:  aluOp = aluAnd;
        opOri:   aluOp = aluOr;
        opLui:   aluOp = aluLui;
        default: regWrite = 1'b0;
      endcase
    end
  end

  // For R-type words the shamt field rides in bits 10:6 of the extended immediate
  assign extImm = signExt ? {{16{slotWord.iType.imm[15]}}, slotWord.iType.imm}
                          : {16'h0000, slotWord.iType.imm};

  // A register being written back this cycle counts as free, the read is bypassed
  function automatic logic busy(input logic [`REG_AW-1:0] r);
    return pending[r] && !(rfWe && rfWaddr == r);
  endfunction

  always_comb hazard = busy(rs) || busy(rt) || (regWrite && busy(dstReg));

  assign idValid = slotValid;
  assign idStall = !slotValid || hazard || shadow || cancelNext;
  assign issue   = !idStall && !exStall;
  assign discard = slotValid && cancelNext;
  // The trap leaves ID/EX for EX/WB in the first cycle without exStall
  assign resolve = shadow && !exStall;
  assign capture = instrReq && !instrAck && (!slotValid || issue || discard);

  always_ff @(posedge CLK or negedge rstN) begin
    if (!rstN) begin
      instrAck   <= 1'b0;
      slotValid  <= 1'b0;
      shadow     <= 1'b0;
      cancelNext <= 1'b0;
      pending    <= '0;
    end else begin
      if (capture) begin
        instrAck <= 1'b1;
      end else if (!instrReq) begin
        instrAck <= 1'b0;
      end
      if (capture) begin
        slotValid <= 1'b1;
      end else if (issue || discard) begin
        slotValid <= 1'b0;
      end
      if (issue && trap) begin
        shadow <= 1'b1;
      end else if (resolve) begin
        shadow <= 1'b0;
      end
      if (resolve && trapTaken) begin
        cancelNext <= 1'b1;
      end else if (discard) begin
        cancelNext <= 1'b0;
      end
      // Clear first so an issue in the same cycle wins on its own register
      if (rfWe) begin
        pending[rfWaddr] <= 1'b0;
      end
      if (issue && regWrite && dstReg != '0) begin
        pending[dstReg] <= 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (capture) begin
      slotWord <= instr;
    end
  end

  regFile regFile_inst (
    .CLK   (CLK),
    .rstN  (rstN),
    .raddr1(rs),
    .raddr2(rt),
    .rdata1(readData1),
    .rdata2(readData2),
    .we    (rfWe),
    .waddr (rfWaddr),
    .wdata (rfWdata)
  );

  // Intake only acknowledges a word the source was requesting
  ackAfterReq: assert property (@(posedge CLK) disable iff (!rstN)
    $rose(instrAck) |-> $past(instrReq));

endmodule

`default_nettype wire

//--- src/idexStage.sv
// ID/EX pipeline register, holds under an execute stall and turns a stalled decode into a bubble
`default_nettype none
`include "core_defines.svh"

module idexStage (
  input  logic               CLK,
  input  logic               rstN,
  input  logic               idStall,
  input  logic               exStall,
  input  pipePkg::aluOp      aluOp,
  input  logic               aluSrcImm,
  input  logic               regWrite,
  input  logic               trap,
  input  pipePkg::trapCond   trapCond,
  input  logic               idValid,
  input  logic [`DATA_W-1:0] readData1,
  input  logic [`DATA_W-1:0] readData2,
  input  logic [`DATA_W-1:0] extImm,
  input  logic [`REG_AW-1:0] dstReg,
  output pipePkg::aluOp      exAluOp,
  output logic               exAluSrcImm,
  output logic               exRegWrite,
  output logic               exTrap,
  output pipePkg::trapCond   exTrapCond,
  output logic               exValid,
  output logic [`DATA_W-1:0] exReadData1,
  output logic [`DATA_W-1:0] exReadData2,
  output logic [`DATA_W-1:0] exExtImm,
  output logic [`REG_AW-1:0] exDstReg
);

  import pipePkg::*;

  // Control fields, everything holds while execute is stalled
  always_ff @(posedge CLK or negedge rstN) begin
    if (!rstN) begin
      exAluOp     <= aluAdd;
      exAluSrcImm <= 1'b0;
      exRegWrite  <= 1'b0;
      exTrap      <= 1'b0;
      exTrapCond  <= trapEq;
      exValid     <= 1'b0;
    end else if (!exStall) begin
      exAluOp     <= aluOp;
      exAluSrcImm <= aluSrcImm;
      exTrapCond  <= trapCond;
      // Masking these three is enough to make the slot a bubble
      exRegWrite  <= regWrite && !idStall;
      exTrap      <= trap && !idStall;
      exValid     <= idValid && !idStall;
    end
  end

  // Operands pass through unchanged, a bubble carries whatever decode presented
  always_ff @(posedge CLK) begin
    if (!exStall) begin
      exReadData1 <= readData1;
      exReadData2 <= readData2;
      exExtImm    <= extImm;
      exDstReg    <= dstReg;
    end
  end

  // Execute sees the same item for as long as it stalls
  holdOnStall: assert property (@(posedge CLK) disable iff (!rstN)
    $past(exStall) |-> $stable({exAluOp, exAluSrcImm, exRegWrite, exTrap, exTrapCond,
                                exValid, exReadData1, exReadData2, exExtImm, exDstReg}));

endmodule

`default_nettype wire

//--- src/executeStage.sv
// Execute stage with the ALU, the trap compare and the EX/WB register feeding writeback
`default_nettype none
`include "core_defines.svh"

module executeStage (
  input  logic               CLK,
  input  logic               rstN,
  input  pipePkg::aluOp      exAluOp,
  input  logic               exAluSrcImm,
  input  logic               exRegWrite,
  input  logic               exTrap,
  input  pipePkg::trapCond   exTrapCond,
  input  logic               exValid,
  input  logic [`DATA_W-1:0] exReadData1,
  input  logic [`DATA_W-1:0] exReadData2,
  input  logic [`DATA_W-1:0] exExtImm,
  input  logic [`REG_AW-1:0] exDstReg,
  output logic               exStall,
  input  logic               wbTake,
  output logic               trapTaken,
  output logic               wbValid,
  output logic [`REG_AW-1:0] wbReg,
  output logic [`DATA_W-1:0] wbData,
  output logic               wbTrap
);

  import pipePkg::*;

  logic [`DATA_W-1:0] opB;
  logic [4:0]         shamt;
  logic [`DATA_W-1:0] aluResult;
  logic               condHolds;

  assign opB = exAluSrcImm ? exExtImm : exReadData2;
  // Shifts take their amount from the shamt bits of the immediate
  assign shamt = exExtImm[10:6];

  always_comb begin
    case (exAluOp)
      aluSub:  aluResult = exReadData1 - opB;
      aluAnd:  aluResult = exReadData1 & opB;
      aluOr:   aluResult = exReadData1 | opB;
      aluXor:  aluResult = exReadData1 ^ opB;
      aluSlt:  aluResult = {{(`DATA_W-1){1'b0}}, $signed(exReadData1) < $signed(opB)};
      aluSll:  aluResult = opB << shamt;
      aluSrl:  aluResult = opB >> shamt;
      aluLui:  aluResult = {opB[15:0], 16'h0000};
      default: aluResult = exReadData1 + opB;
    endcase
  end

  // Equality flipped for trap-if-not-equal
  assign condHolds = (exReadData1 == exReadData2) ^ (exTrapCond == trapNe);

  // EX/WB is full and writeback has not taken it
  assign exStall = wbValid && !wbTake;

  // Pulses only in the cycle the trap moves into EX/WB
  assign trapTaken = exTrap && condHolds && !exStall;

  always_ff @(posedge CLK or negedge rstN) begin
    if (!rstN) begin
      wbValid <= 1'b0;
    end else if (!exStall) begin
      wbValid <= exValid;
    end
  end

  always_ff @(posedge CLK) begin
    if (!exStall) begin
      wbTrap <= exTrap && condHolds;
      // Traps and other non-writing words target register zero, so nothing lands
      wbReg  <= exRegWrite ? exDstReg : '0;
      // A trap reports its first operand
      wbData <= exTrap ? exReadData1 : aluResult;
    end
  end

endmodule

`default_nettype wire

//--- src/writebackStage.sv
// Writeback stage, writes the register file and sends one result record over four-phase req/ack
`default_nettype none
`include "core_defines.svh"

module writebackStage (
  input  logic               CLK,
  input  logic               rstN,
  input  logic               wbValid,
  input  logic [`REG_AW-1:0] wbReg,
  input  logic [`DATA_W-1:0] wbData,
  input  logic               wbTrap,
  output logic               wbTake,
  output logic               rfWe,
  output logic [`REG_AW-1:0] rfWaddr,
  output logic [`DATA_W-1:0] rfWdata,
  output logic               resReq,
  input  logic               resAck,
  output logic [`REG_AW-1:0] resReg,
  output logic [`DATA_W-1:0] resData,
  output logic               resTrap
);

  // Source side of the handshake, idle then request then wait for ack to drop
  localparam logic [1:0] stIdle = 2'd0;
  localparam logic [1:0] stReq  = 2'd1;
  localparam logic [1:0] stWait = 2'd2;

  logic [1:0] state;

  // New items are accepted only from idle, which is where back-pressure comes from
  assign wbTake = (state == stIdle) && wbValid;

  // Register write happens at acceptance and also frees the scoreboard bit
  assign rfWe    = wbTake;
  assign rfWaddr = wbReg;
  assign rfWdata = wbData;

  assign resReq = (state == stReq);

  always_ff @(posedge CLK or negedge rstN) begin
    if (!rstN) begin
      state <= stIdle;
    end else begin
      case (state)
        stIdle:  if (wbValid) state <= stReq;
        stReq:   if (resAck) state <= stWait;
        stWait:  if (!resAck) state <= stIdle;
        default: state <= stIdle;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (wbTake) begin
      resReg  <= wbReg;
      resData <= wbData;
      resTrap <= wbTrap;
    end
  end

  // The record must not change under a raised request
  recordStable: assert property (@(posedge CLK) disable iff (!rstN)
    resReq && $past(resReq) |-> $stable({resReg, resData, resTrap}));

endmodule

`default_nettype wire

//--- src/execCore.sv
// Top level of the execute pipeline, wires decode, ID/EX, execute and writeback together
`default_nettype none
`include "core_defines.svh"

module execCore (
  input  logic               CLK,
  input  logic               rstN,
  input  logic               instrReq,
  output logic               instrAck,
  input  logic [`DATA_W-1:0] instr,
  output logic               resReq,
  input  logic               resAck,
  output logic [`REG_AW-1:0] resReg,
  output logic [`DATA_W-1:0] resData,
  output logic               resTrap
);

  import pipePkg::*;

  // Decode to ID/EX
  aluOp               idAluOp;
  trapCond            idTrapCond;
  logic               idAluSrcImm;
  logic               idRegWrite;
  logic               idTrap;
  logic               idValid;
  logic               idStall;
  logic [`DATA_W-1:0] idReadData1;
  logic [`DATA_W-1:0] idReadData2;
  logic [`DATA_W-1:0] idExtImm;
  logic [`REG_AW-1:0] idDstReg;

  // ID/EX to execute
  aluOp               exAluOp;
  trapCond            exTrapCond;
  logic               exAluSrcImm;
  logic               exRegWrite;
  logic               exTrap;
  logic               exValid;
  logic [`DATA_W-1:0] exReadData1;
  logic [`DATA_W-1:0] exReadData2;
  logic [`DATA_W-1:0] exExtImm;
  logic [`REG_AW-1:0] exDstReg;
  logic               exStall;
  logic               trapTaken;

  // EX/WB handoff and the register-file write
  logic               wbValid;
  logic [`REG_AW-1:0] wbReg;
  logic [`DATA_W-1:0] wbData;
  logic               wbTrap;
  logic               wbTake;
  logic               rfWe;
  logic [`REG_AW-1:0] rfWaddr;
  logic [`DATA_W-1:0] rfWdata;

  decodeStage decodeStage_inst (
    .CLK(CLK), .rstN(rstN),
    .instrReq(instrReq), .instrAck(instrAck), .instr(instr),
    .rfWe(rfWe), .rfWaddr(rfWaddr), .rfWdata(rfWdata),
    .trapTaken(trapTaken), .exStall(exStall),
    .aluOp(idAluOp), .aluSrcImm(idAluSrcImm), .regWrite(idRegWrite),
    .trap(idTrap), .trapCond(idTrapCond), .idValid(idValid),
    .readData1(idReadData1), .readData2(idReadData2),
    .extImm(idExtImm), .dstReg(idDstReg), .idStall(idStall)
  );

  idexStage idexStage_inst (
    .CLK(CLK), .rstN(rstN), .idStall(idStall), .exStall(exStall),
    .aluOp(idAluOp), .aluSrcImm(idAluSrcImm), .regWrite(idRegWrite),
    .trap(idTrap), .trapCond(idTrapCond), .idValid(idValid),
    .readData1(idReadData1), .readData2(idReadData2),
    .extImm(idExtImm), .dstReg(idDstReg),
    .exAluOp(exAluOp), .exAluSrcImm(exAluSrcImm), .exRegWrite(exRegWrite),
    .exTrap(exTrap), .exTrapCond(exTrapCond), .exValid(exValid),
    .exReadData1(exReadData1), .exReadData2(exReadData2),
    .exExtImm(exExtImm), .exDstReg(exDstReg)
  );

  executeStage executeStage_inst (
    .CLK(CLK), .rstN(rstN),
    .exAluOp(exAluOp), .exAluSrcImm(exAluSrcImm), .exRegWrite(exRegWrite),
    .exTrap(exTrap), .exTrapCond(exTrapCond), .exValid(exValid),
    .exReadData1(exReadData1), .exReadData2(exReadData2),
    .exExtImm(exExtImm), .exDstReg(exDstReg),
    .exStall(exStall), .wbTake(wbTake), .trapTaken(trapTaken),
    .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData), .wbTrap(wbTrap)
  );

  writebackStage writebackStage_inst (
    .CLK(CLK), .rstN(rstN),
    .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData), .wbTrap(wbTrap),
    .wbTake(wbTake), .rfWe(rfWe), .rfWaddr(rfWaddr), .rfWdata(rfWdata),
    .resReq(resReq), .resAck(resAck),
    .resReg(resReg), .resData(resData), .resTrap(resTrap)
  );

endmodule

`default_nettype wire

//--- dv/execCoreTb.sv
// Testbench for the execute pipeline, replays the stimulus file through both handshakes
`default_nettype none
`include "core_defines.svh"

module execCoreTb;

  // Cycles any single handshake wait may take before the run is abandoned
  localparam int waitLimit = 200;

  logic               CLK;
  logic               rstN;
  logic               instrReq;
  logic               instrAck;
  logic [`DATA_W-1:0] instr;
  logic               resReq;
  logic               resAck;
  logic [`REG_AW-1:0] resReg;
  logic [`DATA_W-1:0] resData;
  logic               resTrap;

  // Every word in program order, cancelled ones included
  logic [`DATA_W-1:0] wordQ [$];

  // Expected records in retirement order, each tagged with its test number
  int                 expTestQ [$];
  logic [`REG_AW-1:0] expRegQ [$];
  logic [`DATA_W-1:0] expDataQ [$];
  logic               expTrapQ [$];

  int checkCount;
  int errorCount;
  int extraReqs;
  int resetErrBase;

  execCore execCore_inst (
    .CLK     (CLK),
    .rstN    (rstN),
    .instrReq(instrReq),
    .instrAck(instrAck),
    .instr   (instr),
    .resReq  (resReq),
    .resAck  (resAck),
    .resReg  (resReg),
    .resData (resData),
    .resTrap (resTrap)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  task automatic checkValue(input string what, input logic [31:0] got, input logic [31:0] exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("error at time %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic abortRun(input string why);
    $display("%s (time %0t)", why, $time);
    $display("Errors found");
    $finish;
  endtask

  task automatic waitInstrAck(input logic level);
    int cycles;
    cycles = 0;
    while (instrAck !== level && cycles < waitLimit) begin
      @(negedge CLK);
      cycles++;
    end
    if (instrAck !== level) abortRun($sformatf("instrAck never went to %0b", level));
  endtask

  task automatic waitResReq(input logic level);
    int cycles;
    cycles = 0;
    while (resReq !== level && cycles < waitLimit) begin
      @(negedge CLK);
      cycles++;
    end
    if (resReq !== level) abortRun($sformatf("resReq never went to %0b", level));
  endtask

  // Lines hold a test number and a word, then either a record or the cancel marker
  task automatic loadStimulus();
    int                 fd;
    int                 n;
    int                 lineNo;
    int                 testNum;
    int                 regNum;
    int                 trapBit;
    logic [`DATA_W-1:0] word;
    logic [`DATA_W-1:0] data;
    logic [8*8-1:0]     marker;
    string              lineStr;
    lineNo = 0;
    fd = $fopen("dv/execCore_stimulus.txt", "r");
    if (fd == 0) begin
      abortRun("could not open the stimulus file dv/execCore_stimulus.txt");
    end else begin
      while (!$feof(fd)) begin
        lineStr = "";
        n = $fgets(lineStr, fd);
        lineNo++;
        if (n == 0 || lineStr.len() == 0 || lineStr[0] == "#") continue;
        n = $sscanf(lineStr, "%d %h %d %h %d", testNum, word, regNum, data, trapBit);
        if (n == 5) begin
          wordQ.push_back(word);
          expTestQ.push_back(testNum);
          expRegQ.push_back(regNum[`REG_AW-1:0]);
          expDataQ.push_back(data);
          expTrapQ.push_back(trapBit[0]);
        end else if (n == 2) begin
          // A cancelled word is sent but must never retire
          n = $sscanf(lineStr, "%d %h %s", testNum, word, marker);
          if (n == 3 && marker == "cancel") begin
            wordQ.push_back(word);
          end else begin
            abortRun($sformatf("stimulus line %0d has an unknown marker", lineNo));
          end
        end else if (n > 0) begin
          abortRun($sformatf("stimulus line %0d is incomplete", lineNo));
        end
      end
      $fclose(fd);
    end
  endtask

  // Source side of the instruction port, one full four-phase cycle per word
  task automatic sendWords();
    int idx;
    for (idx = 0; idx < wordQ.size(); idx++) begin
      instr    = wordQ[idx];
      instrReq = 1'b1;
      waitInstrAck(1'b1);
      instrReq = 1'b0;
      waitInstrAck(1'b0);
    end
  endtask

  // Sink side of the result port with a random ack delay of 0 to 5 cycles
  task automatic collectRecords();
    int idx;
    int delay;
    int errBase;
    int records;
    errBase = errorCount;
    records = 0;
    for (idx = 0; idx < expRegQ.size(); idx++) begin
      waitResReq(1'b1);
      checkValue($sformatf("record %0d resReg", idx), resReg, expRegQ[idx]);
      checkValue($sformatf("record %0d resData", idx), resData, expDataQ[idx]);
      checkValue($sformatf("record %0d resTrap", idx), resTrap, expTrapQ[idx]);
      records++;
      delay = $urandom % 6;
      repeat (delay) @(negedge CLK);
      resAck = 1'b1;
      waitResReq(1'b0);
      resAck = 1'b0;
      // A test is finished once its last expected record has gone through
      if (idx + 1 == expRegQ.size() || expTestQ[idx + 1] != expTestQ[idx]) begin
        $display("test %0d: %0d records, %0d errors", expTestQ[idx], records,
                 errorCount - errBase);
        errBase = errorCount;
        records = 0;
      end
    end
  endtask

  initial begin
    // Fixed seed so the ack delays repeat from run to run
    void'($urandom(38));
    rstN       = 1'b0;
    instrReq   = 1'b0;
    instr      = '0;
    resAck     = 1'b0;
    checkCount = 0;
    errorCount = 0;
    extraReqs  = 0;
    loadStimulus();
    repeat (2) @(negedge CLK);
    rstN = 1'b1;
    @(negedge CLK);
    // Both handshakes are quiet before the first request
    resetErrBase = errorCount;
    checkValue("resReq after reset", resReq, 1'b0);
    checkValue("instrAck after reset", instrAck, 1'b0);
    $display("test 6: reset state, %0d errors", errorCount - resetErrBase);
    fork
      sendWords();
      collectRecords();
    join
    // A cancelled word or a duplicate would show up as a late request
    repeat (40) begin
      @(negedge CLK);
      if (resReq) extraReqs++;
    end
    checkValue("requests after the last record", extraReqs, 0);
    $display("checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/execCore_stimulus.txt
# test  instr     resReg  resData   resTrap   (instr and resData in hex, the rest decimal)
# a cancelled word has the marker cancel where its record would be
1 20010015  1 00000015 0
1 20020007  2 00000007 0
1 00221820  3 0000001c 0
1 00222022  4 0000000e 0
1 00222824  5 00000005 0
1 00223025  6 00000017 0
1 00223826  7 00000012 0
1 0041402a  8 00000001 0
1 00024900  9 00000070 0
1 00015082 10 00000005 0
2 200bfff0 11 fffffff0 0
2 316cff0f 12 0000ff00 0
2 340d8001 13 00008001 0
2 296efff8 14 00000001 0
2 3c0f1234 15 12340000 0
2 20000055  0 00000055 0
2 00008020 16 00000000 0
3 20110003 17 00000003 0
3 02319020 18 00000006 0
3 02519020 18 00000009 0
3 001298c0 19 00000048 0
4 341500a5 21 000000a5 0
4 3416005a 22 0000005a 0
4 02b6b826 23 000000ff 0
4 22f80001 24 00000100 0
5 00210034  0 00000015 1
5 201d0011 cancel
5 03a1e020 28 00000015 0
5 00210036  0 00000015 0
5 201e0030 30 00000030 0

//--- vlog.f
+incdir+common
common/isaPkg.sv
common/pipePkg.sv
decode/regFile.sv
decode/decodeStage.sv
src/idexStage.sv
src/executeStage.sv
src/writebackStage.sv
src/execCore.sv
dv/execCoreTb.sv

//--- Bender.yml
package:
  name: execCore

sources:
  - include_dirs:
      - common
    files:
      - common/isaPkg.sv
      - common/pipePkg.sv
      - decode/regFile.sv
      - decode/decodeStage.sv
      - src/idexStage.sv
      - src/executeStage.sv
      - src/writebackStage.sv
      - src/execCore.sv
      - target: test
        files:
          - dv/execCoreTb.sv
